/* Makefile */
# Verilator build for the execute core testbench

VERILATOR  ?= verilator
TOP        := tb_exec_core
FILELIST   := list.f
BUILD_DIR  := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert
PASS_TEXT  := All checks passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# the run fails unless the pass line shows up in the output
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

/* hw/alu.sv */
// integer alu
// rv32i add, sub, logic, shift and set-less-than operations

`timescale 1ns/1ns

module alu
    import rv32_isa_pkg::*;
    import exec_ctrl_pkg::*;
(
    input  alu_op_t alu_op,
    input  word_t   port_a,
    input  word_t   port_b,
    output word_t   port_out
);

    logic [4:0] shamt;
    logic       lt_signed, lt_unsigned;

    // shift amount from low five bits
    assign shamt = port_b[4:0];

    assign lt_signed   = $signed(port_a) < $signed(port_b);
    assign lt_unsigned = port_a < port_b;

    always_comb begin
        case (alu_op)
            ALU_ADD:  port_out = port_a + port_b;
            ALU_SUB:  port_out = port_a - port_b;
            ALU_SLL:  port_out = port_a << shamt;
            ALU_SLT:  port_out = {{(XLEN-1){1'b0}}, lt_signed};
            ALU_SLTU: port_out = {{(XLEN-1){1'b0}}, lt_unsigned};
            ALU_XOR:  port_out = port_a ^ port_b;
            ALU_SRL:  port_out = port_a >> shamt;
            // arithmetic, sign bit fills from the left
            ALU_SRA:  port_out = word_t'($signed(port_a) >>> shamt);
            ALU_OR:   port_out = port_a | port_b;
            ALU_AND:  port_out = port_a & port_b;
            default:  port_out = '0;
        endcase
    end

endmodule

/* hw/exec_core.sv */
// execute core top level
// decode register, register file and execute stage of a two-stage rv32i pipe

`timescale 1ns/1ns

module exec_core
    import rv32_isa_pkg::*;
    import exec_ctrl_pkg::*;
(
    input  logic     CLK,
    input  logic     nRST,
    input  logic     instr_valid,
    input  word_t    instr,
    input  word_t    pc,
    output logic     res_valid,
    output reg_idx_t res_rd,
    output word_t    res_data,
    output word_t    res_next_pc,
    output logic     res_taken,
    output logic     res_illegal
);

    // decode register outputs
    logic     dec_valid, dec_rd_wen, dec_is_jal, dec_is_jalr, dec_illegal;
    word_t    dec_pc, dec_imm;
    reg_idx_t dec_rs1, dec_rs2, dec_rd;
    alu_op_t  dec_alu_op;
    a_sel_t   dec_a_sel;
    b_sel_t   dec_b_sel;
    br_type_t dec_br_type;
    wb_sel_t  dec_wb_sel;

    word_t    rs1_data, rs2_data;
    logic     wb_en;

    instr_decode u_decode (
        .CLK, .nRST, .instr_valid, .instr, .pc,
        .dec_valid, .dec_pc, .dec_rs1, .dec_rs2, .dec_rd, .dec_rd_wen,
        .dec_alu_op, .dec_a_sel, .dec_b_sel, .dec_imm, .dec_br_type,
        .dec_is_jal, .dec_is_jalr, .dec_wb_sel, .dec_illegal
    );

    // writeback comes straight from the result register
    reg_file u_reg_file (
        .CLK, .nRST,
        .rs1 (dec_rs1), .rs2 (dec_rs2), .rs1_data, .rs2_data,
        .wen (wb_en), .rd (res_rd), .wdata (res_data)
    );

    exec_stage u_exec (
        .CLK, .nRST,
        .dec_valid, .dec_pc, .dec_rs1, .dec_rs2, .dec_rd, .dec_rd_wen,
        .dec_alu_op, .dec_a_sel, .dec_b_sel, .dec_imm, .dec_br_type,
        .dec_is_jal, .dec_is_jalr, .dec_wb_sel, .dec_illegal,
        .rs1_data, .rs2_data,
        .wb_en, .wb_rd (res_rd), .wb_data (res_data),
        .res_valid, .res_next_pc, .res_taken, .res_illegal
    );

endmodule

/* hw/exec_ctrl_pkg.sv */
// execute pipeline control types
// alu operation, operand selects, branch condition and writeback source

package exec_ctrl_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_t;

    // operand a source, zero is used by lui
    typedef enum logic [1:0] {
        A_RS1,
        A_PC,
        A_ZERO
    } a_sel_t;

    typedef enum logic {
        B_RS2,
        B_IMM
    } b_sel_t;

    // branch condition, none for every non-branch
    typedef enum logic [2:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_LT,
        BR_GE,
        BR_LTU,
        BR_GEU
    } br_type_t;

    // jumps write the return address
    typedef enum logic {
        WB_ALU,
        WB_PC4
    } wb_sel_t;

endpackage

/* hw/exec_stage.sv */
// execute stage
// forwarding, operand muxes, branch and jump resolution, result register
// the result register also drives register file writeback

`timescale 1ns/1ns

module exec_stage
    import rv32_isa_pkg::*;
    import exec_ctrl_pkg::*;
(
    input  logic     CLK,
    input  logic     nRST,
    input  logic     dec_valid,
    input  word_t    dec_pc,
    input  reg_idx_t dec_rs1,
    input  reg_idx_t dec_rs2,
    input  reg_idx_t dec_rd,
    input  logic     dec_rd_wen,
    input  alu_op_t  dec_alu_op,
    input  a_sel_t   dec_a_sel,
    input  b_sel_t   dec_b_sel,
    input  word_t    dec_imm,
    input  br_type_t dec_br_type,
    input  logic     dec_is_jal,
    input  logic     dec_is_jalr,
    input  wb_sel_t  dec_wb_sel,
    input  logic     dec_illegal,
    input  word_t    rs1_data,
    input  word_t    rs2_data,
    output logic     wb_en,
    output reg_idx_t wb_rd,
    output word_t    wb_data,
    output logic     res_valid,
    output word_t    res_next_pc,
    output logic     res_taken,
    output logic     res_illegal
);

    word_t rs1_fwd, rs2_fwd;
    word_t port_a, port_b, alu_out;
    word_t pc4, pc_imm, jalr_target, next_pc, result;
    logic  br_taken, taken, writes;

    // previous result not yet in the register file, x0 never forwarded
    assign rs1_fwd = (wb_en && wb_rd != '0 && wb_rd == dec_rs1) ? wb_data : rs1_data;
    assign rs2_fwd = (wb_en && wb_rd != '0 && wb_rd == dec_rs2) ? wb_data : rs2_data;

    always_comb begin
        case (dec_a_sel)
            A_RS1:   port_a = rs1_fwd;
            A_PC:    port_a = dec_pc;
            default: port_a = '0;
        endcase
    end

    assign port_b = (dec_b_sel == B_IMM) ? dec_imm : rs2_fwd;

    alu u_alu (
        .alu_op   (dec_alu_op),
        .port_a   (port_a),
        .port_b   (port_b),
        .port_out (alu_out)
    );

    // branch compare on forwarded sources
    always_comb begin
        case (dec_br_type)
            BR_EQ:   br_taken = rs1_fwd == rs2_fwd;
            BR_NE:   br_taken = rs1_fwd != rs2_fwd;
            BR_LT:   br_taken = $signed(rs1_fwd) < $signed(rs2_fwd);
            BR_GE:   br_taken = $signed(rs1_fwd) >= $signed(rs2_fwd);
            BR_LTU:  br_taken = rs1_fwd < rs2_fwd;
            BR_GEU:  br_taken = rs1_fwd >= rs2_fwd;
            default: br_taken = 1'b0;
        endcase
    end

    // branch and jal share the pc-relative adder
    assign pc4         = dec_pc + word_t'(4);
    assign pc_imm      = dec_pc + dec_imm;
    assign jalr_target = (rs1_fwd + dec_imm) & ~word_t'(1);

    assign taken   = dec_is_jal || dec_is_jalr || br_taken;
    assign next_pc = dec_is_jalr ? jalr_target : (taken ? pc_imm : pc4);

    assign writes = dec_valid && dec_rd_wen && !dec_illegal;
    // nothing written means a zero result
    assign result = !writes ? '0 : ((dec_wb_sel == WB_PC4) ? pc4 : alu_out);

    // result register, control part
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            res_valid   <= 1'b0;
            wb_en       <= 1'b0;
            res_taken   <= 1'b0;
            res_illegal <= 1'b0;
        end else begin
            res_valid   <= dec_valid;
            wb_en       <= writes;
            res_taken   <= dec_valid && taken;
            res_illegal <= dec_valid && dec_illegal;
        end
    end

    // result register, payload part
    always_ff @(posedge CLK) begin
        wb_rd       <= dec_rd;
        wb_data     <= result;
        res_next_pc <= next_pc;
    end

endmodule

/* hw/instr_decode.sv */
// instruction decoder with decode register
// splits fields, builds immediates, flags illegal encodings

`timescale 1ns/1ns

module instr_decode
    import rv32_isa_pkg::*;
    import exec_ctrl_pkg::*;
(
    input  logic     CLK,
    input  logic     nRST,
    input  logic     instr_valid,
    input  word_t    instr,
    input  word_t    pc,
    output logic     dec_valid,
    output word_t    dec_pc,
    output reg_idx_t dec_rs1,
    output reg_idx_t dec_rs2,
    output reg_idx_t dec_rd,
    output logic     dec_rd_wen,
    output alu_op_t  dec_alu_op,
    output a_sel_t   dec_a_sel,
    output b_sel_t   dec_b_sel,
    output word_t    dec_imm,
    output br_type_t dec_br_type,
    output logic     dec_is_jal,
    output logic     dec_is_jalr,
    output wb_sel_t  dec_wb_sel,
    output logic     dec_illegal
);

    opcode_t    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_i, imm_b, imm_u, imm_j, imm_shamt;
    logic       rd_wen, is_jal, is_jalr, illegal;
    alu_op_t    alu_op;
    a_sel_t     a_sel;
    b_sel_t     b_sel;
    word_t      imm;
    br_type_t   br_type;
    wb_sel_t    wb_sel;

    // funct3 to alu op, alt picks sub or sra
    function automatic alu_op_t f3_to_alu(input logic [2:0] f3, input logic alt);
        alu_op_t op;
        case (f3)
            F3_ADD_SUB: op = alt ? ALU_SUB : ALU_ADD;
            F3_SLL:     op = ALU_SLL;
            F3_SLT:     op = ALU_SLT;
            F3_SLTU:    op = ALU_SLTU;
            F3_XOR:     op = ALU_XOR;
            F3_SRL_SRA: op = alt ? ALU_SRA : ALU_SRL;
            F3_OR:      op = ALU_OR;
            default:    op = ALU_AND;
        endcase
        return op;
    endfunction

    assign opcode = opcode_t'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // sign-extended immediates per format
    assign imm_i     = {{20{instr[31]}}, instr[31:20]};
    assign imm_b     = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u     = {instr[31:12], 12'b0};
    assign imm_j     = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
    assign imm_shamt = {{(XLEN-5){1'b0}}, instr[24:20]};

    always_comb begin
        // defaults describe a non-writing addi
        rd_wen  = 1'b0;
        alu_op  = ALU_ADD;
        a_sel   = A_RS1;
        b_sel   = B_IMM;
        imm     = imm_i;
        br_type = BR_NONE;
        is_jal  = 1'b0;
        is_jalr = 1'b0;
        wb_sel  = WB_ALU;
        illegal = 1'b0;
        case (opcode)
            OPC_OP: begin
                rd_wen = 1'b1;
                b_sel  = B_RS2;
                alu_op = f3_to_alu(funct3, instr[30]);
                // only add/sub and srl/sra have an alternate funct7
                if (!(funct7 == 7'b0000000 ||
                      (funct7 == 7'b0100000 &&
                       (funct3 == F3_ADD_SUB || funct3 == F3_SRL_SRA)))) begin
                    illegal = 1'b1;
                end
            end
            OPC_OP_IMM: begin
                rd_wen = 1'b1;
                // addi never turns into sub
                alu_op = f3_to_alu(funct3, (funct3 == F3_SRL_SRA) && instr[30]);
                if (funct3 == F3_SLL || funct3 == F3_SRL_SRA) begin
                    imm = imm_shamt;
                end
            end
            OPC_LUI: begin
                rd_wen = 1'b1;
                a_sel  = A_ZERO;
                imm    = imm_u;
            end
            OPC_AUIPC: begin
                rd_wen = 1'b1;
                a_sel  = A_PC;
                imm    = imm_u;
            end
            OPC_JAL: begin
                rd_wen = 1'b1;
                is_jal = 1'b1;
                wb_sel = WB_PC4;
                imm    = imm_j;
            end
            OPC_JALR: begin
                rd_wen  = 1'b1;
                is_jalr = 1'b1;
                wb_sel  = WB_PC4;
            end
            OPC_BRANCH: begin
                imm = imm_b;
                case (funct3)
                    F3_BEQ:  br_type = BR_EQ;
                    F3_BNE:  br_type = BR_NE;
                    F3_BLT:  br_type = BR_LT;
                    F3_BGE:  br_type = BR_GE;
                    F3_BLTU: br_type = BR_LTU;
                    F3_BGEU: br_type = BR_GEU;
                    default: br_type = BR_NONE;
                endcase
            end
            default: illegal = 1'b1;
        endcase
        // illegal instructions write nothing
        if (illegal) begin
            rd_wen = 1'b0;
        end
    end

    // decode register, control part
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            dec_valid   <= 1'b0;
            dec_rd_wen  <= 1'b0;
            dec_br_type <= BR_NONE;
            dec_is_jal  <= 1'b0;
            dec_is_jalr <= 1'b0;
            dec_illegal <= 1'b0;
        end else begin
            dec_valid   <= instr_valid;
            dec_rd_wen  <= rd_wen;
            dec_br_type <= br_type;
            dec_is_jal  <= is_jal;
            dec_is_jalr <= is_jalr;
            dec_illegal <= illegal;
        end
    end

    // decode register, payload part
    always_ff @(posedge CLK) begin
        dec_pc     <= pc;
        dec_rs1    <= instr[19:15];
        dec_rs2    <= instr[24:20];
        dec_rd     <= instr[11:7];
        dec_alu_op <= alu_op;
        dec_a_sel  <= a_sel;
        dec_b_sel  <= b_sel;
        dec_imm    <= imm;
        dec_wb_sel <= wb_sel;
    end

endmodule

/* hw/reg_file.sv */
// integer register file
// two asynchronous read ports, one synchronous write port, x0 fixed at zero

`timescale 1ns/1ns

module reg_file
    import rv32_isa_pkg::*;
(
    input  logic     CLK,
    input  logic     nRST,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    output word_t    rs1_data,
    output word_t    rs2_data,
    input  logic     wen,
    input  reg_idx_t rd,
    input  word_t    wdata
);

    word_t regs [NUM_REGS];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && rd != '0) begin
            // x0 writes dropped here
            regs[rd] <= wdata;
        end
    end

    // combinational reads
    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

/* hw/rv32_isa_pkg.sv */
// rv32i instruction set definitions
// data word and register index types, major opcodes, funct3 codes

package rv32_isa_pkg;

    // data path width and architectural register count
    localparam int XLEN     = 32;
    localparam int NUM_REGS = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [$clog2(NUM_REGS)-1:0] reg_idx_t;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011
    } opcode_t;

    // funct3 for OP and OP-IMM
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // funct3 for BRANCH
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

endpackage

/* list.f */
hw/rv32_isa_pkg.sv
hw/exec_ctrl_pkg.sv
hw/alu.sv
hw/reg_file.sv
hw/instr_decode.sv
hw/exec_stage.sv
hw/exec_core.sv
testbench/tb_exec_core.sv

/* testbench/tb_exec_core.sv */
// testbench for the rv32i execute core
// random instruction stream checked against a reference model of the isa rules

`timescale 1ns/1ns

module tb_exec_core
    import rv32_isa_pkg::*;
();

    // expected result of one instruction
    typedef struct packed {
        reg_idx_t rd;
        word_t    data;
        word_t    next_pc;
        logic     taken;
        logic     illegal;
        logic     wen;
    } exp_t;

    logic     CLK;
    logic     nRST;
    logic     instr_valid;
    word_t    instr;
    word_t    pc;
    logic     res_valid;
    reg_idx_t res_rd;
    word_t    res_data;
    word_t    res_next_pc;
    logic     res_taken;
    logic     res_illegal;

    integer seed = 67961;
    int     errors = 0;
    int     cyc = 0;
    // architectural state as the stream should leave it
    word_t  shadow [NUM_REGS];
    exp_t   exp_q [$];
    string  name_q [$];
    int     cyc_q [$];
    exp_t   exp_rec;
    string  exp_name;
    int     exp_cyc;

    exec_core u_dut (
        .CLK, .nRST, .instr_valid, .instr, .pc,
        .res_valid, .res_rd, .res_data, .res_next_pc, .res_taken, .res_illegal
    );

    initial CLK = 1'b0;
    always #4 CLK = ~CLK;

    // cycle count for latency checks
    always @(posedge CLK) cyc <= cyc + 1;

    function automatic word_t rnd();
        rnd = $random(seed);
    endfunction

    // instruction encoders
    function automatic word_t r_type(input logic [6:0] f7, input reg_idx_t rs2, rs1,
                                     input logic [2:0] f3, input reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic word_t i_type(input logic [11:0] imm, input reg_idx_t rs1,
                                     input logic [2:0] f3, input reg_idx_t rd,
                                     input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t u_type(input logic [19:0] imm, input reg_idx_t rd,
                                     input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic word_t b_type(input logic [12:0] imm, input reg_idx_t rs2, rs1,
                                     input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic word_t j_type(input logic [20:0] imm, input reg_idx_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    // isa alu, alt means sub or sra
    function automatic word_t alu_ref(input logic [2:0] f3, input logic alt, input word_t a, b);
        case (f3)
            F3_ADD_SUB: return alt ? a - b : a + b;
            F3_SLL:     return a << b[4:0];
            F3_SLT:     return {31'b0, $signed(a) < $signed(b)};
            F3_SLTU:    return {31'b0, a < b};
            F3_XOR:     return a ^ b;
            F3_SRL_SRA: return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            F3_OR:      return a | b;
            default:    return a & b;
        endcase
    endfunction

    // expected outputs from instruction, pc and shadow registers
    function automatic exp_t exec_ref(input word_t ins, input word_t pcv);
        exp_t       e;
        logic [2:0] f3;
        word_t      a, b, imm_i, imm_b, imm_u, imm_j;
        logic       cond;
        f3    = ins[14:12];
        a     = shadow[ins[19:15]];
        b     = shadow[ins[24:20]];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_u = {ins[31:12], 12'b0};
        imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        cond  = 1'b0;
        e         = '0;
        e.rd      = ins[11:7];
        e.next_pc = pcv + 32'd4;
        case (opcode_t'(ins[6:0]))
            OPC_OP: begin
                // only add/sub and srl/sra accept funct7 0x20
                if (ins[31:25] == 7'h00 ||
                    (ins[31:25] == 7'h20 && (f3 == F3_ADD_SUB || f3 == F3_SRL_SRA))) begin
                    e.wen  = 1'b1;
                    e.data = alu_ref(f3, ins[30], a, b);
                end else begin
                    e.illegal = 1'b1;
                end
            end
            OPC_OP_IMM: begin
                e.wen = 1'b1;
                if (f3 == F3_SLL || f3 == F3_SRL_SRA) begin
                    e.data = alu_ref(f3, ins[30], a, {27'b0, ins[24:20]});
                end else begin
                    e.data = alu_ref(f3, 1'b0, a, imm_i);
                end
            end
            OPC_LUI: begin
                e.wen  = 1'b1;
                e.data = imm_u;
            end
            OPC_AUIPC: begin
                e.wen  = 1'b1;
                e.data = pcv + imm_u;
            end
            OPC_JAL: begin
                e.wen     = 1'b1;
                e.data    = pcv + 32'd4;
                e.taken   = 1'b1;
                e.next_pc = pcv + imm_j;
            end
            OPC_JALR: begin
                e.wen     = 1'b1;
                e.data    = pcv + 32'd4;
                e.taken   = 1'b1;
                e.next_pc = (a + imm_i) & 32'hFFFF_FFFE;
            end
            OPC_BRANCH: begin
                case (f3)
                    F3_BEQ:  cond = a == b;
                    F3_BNE:  cond = a != b;
                    F3_BLT:  cond = $signed(a) < $signed(b);
                    F3_BGE:  cond = $signed(a) >= $signed(b);
                    F3_BLTU: cond = a < b;
                    F3_BGEU: cond = a >= b;
                    default: cond = 1'b0;
                endcase
                e.taken = cond;
                if (cond) begin
                    e.next_pc = pcv + imm_b;
                end
            end
            default: e.illegal = 1'b1;
        endcase
        return e;
    endfunction

    // one strobe, held until the next issue or idle
    task automatic issue(input word_t ins, input string name);
        exp_t  e;
        word_t pcv;
        pcv = rnd() & 32'hFFFF_FFFC;
        @(posedge CLK);
        #1;
        e = exec_ref(ins, pcv);
        instr_valid = 1'b1;
        instr       = ins;
        pc          = pcv;
        exp_q.push_back(e);
        name_q.push_back(name);
        cyc_q.push_back(cyc);
        if (e.wen && e.rd != '0) begin
            shadow[e.rd] = e.data;
        end
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge CLK);
            #1;
            instr_valid = 1'b0;
        end
    endtask

    // wait for outstanding results, bounded
    task automatic drain();
        int t;
        t = 0;
        while (exp_q.size() != 0 && t < 20) begin
            @(posedge CLK);
            t++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout: %0d results never arrived", exp_q.size());
            errors++;
        end
    endtask

    task automatic check_word(input string test, input string field,
                              input word_t exp_v, input word_t act_v);
        assert (act_v === exp_v) else begin
            $display("ERR %s %s expected %h actual %h", test, field, exp_v, act_v);
            errors++;
        end
    endtask

    // outputs settle after the rising edge, sample on the falling one
    always @(negedge CLK) begin
        if (res_valid === 1'b1) begin
            assert (exp_q.size() != 0) else begin
                $display("result valid with no instruction outstanding");
                errors++;
            end
            if (exp_q.size() != 0) begin
                exp_rec  = exp_q.pop_front();
                exp_name = name_q.pop_front();
                exp_cyc  = cyc_q.pop_front();
                assert (cyc - exp_cyc == 2) else begin
                    $display("%s result came %0d cycles after its strobe instead of 2",
                             exp_name, cyc - exp_cyc);
                    errors++;
                end
                check_word(exp_name, "rd", {27'b0, exp_rec.rd}, {27'b0, res_rd});
                check_word(exp_name, "data", exp_rec.data, res_data);
                check_word(exp_name, "next_pc", exp_rec.next_pc, res_next_pc);
                check_word(exp_name, "taken", {31'b0, exp_rec.taken}, {31'b0, res_taken});
                check_word(exp_name, "illegal", {31'b0, exp_rec.illegal},
                           {31'b0, res_illegal});
            end
        end
    end

    initial begin
        word_t      r;
        reg_idx_t   rd, rs1, rs2;
        logic [2:0] f3;
        logic       alt;
        logic [11:0] imm;
        nRST        = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        pc          = '0;
        for (int i = 0; i < NUM_REGS; i++) begin
            shadow[i] = '0;
        end
        repeat (5) @(posedge CLK);
        #1;
        nRST = 1'b1;
        // quiet pipe after reset, checker flags any result
        idle(4);
        issue(r_type(7'h00, 5'd2, 5'd1, F3_ADD_SUB, 5'd5), "zero_read");
        issue(r_type(7'h00, 5'd4, 5'd3, F3_OR, 5'd6), "zero_read");
        // preload x1..x15, addi depends on the lui right before it
        for (int i = 1; i < 16; i++) begin
            r = rnd();
            issue(u_type(r[31:12], reg_idx_t'(i), OPC_LUI), "preload_lui");
            issue(i_type(r[11:0], reg_idx_t'(i), F3_ADD_SUB, reg_idx_t'(i), OPC_OP_IMM),
                  "preload_addi");
        end
        // random alu stream over x0..x15, many back-to-back dependencies
        for (int i = 0; i < 80; i++) begin
            r   = rnd();
            rd  = {1'b0, r[3:0]};
            rs1 = {1'b0, r[7:4]};
            rs2 = {1'b0, r[11:8]};
            f3  = r[14:12];
            alt = r[15] && (f3 == F3_ADD_SUB || f3 == F3_SRL_SRA);
            if (r[16]) begin
                issue(r_type(alt ? 7'h20 : 7'h00, rs2, rs1, f3, rd), "alu_op");
            end else begin
                imm = r[31:20];
                // shift immediates carry shamt and the sra bit only
                if (f3 == F3_SLL || f3 == F3_SRL_SRA) begin
                    imm = {1'b0, alt, 5'b0, r[24:20]};
                end
                issue(i_type(imm, rs1, f3, rd, OPC_OP_IMM), "alu_op_imm");
            end
            if (r[18:17] == 2'b00) begin
                idle(r[19] ? 2 : 1);
            end
        end
        // all six conditions, equal sources forced now and then
        for (int i = 0; i < 36; i++) begin
            r   = rnd();
            rs1 = {1'b0, r[3:0]};
            rs2 = r[4] ? rs1 : {1'b0, r[8:5]};
            f3  = (i % 6 < 2) ? 3'(i % 6) : 3'(i % 6 + 2);
            issue(b_type({r[31:20], 1'b0}, rs2, rs1, f3), "branch");
        end
        // jumps, odd jalr sums check bit 0 clearing
        for (int i = 0; i < 8; i++) begin
            r = rnd();
            issue(j_type({r[20:1], 1'b0}, {1'b0, r[24:21]}), "jal");
            issue(i_type(r[31:20], {1'b0, r[28:25]}, 3'b000, {1'b0, r[3:0]}, OPC_JALR),
                  "jalr");
            issue(u_type(r[31:12], {1'b0, r[7:4]}, OPC_AUIPC), "auipc");
        end
        // mul and load encodings, then read the target back
        for (int i = 0; i < 6; i++) begin
            r  = rnd();
            rd = {1'b0, r[3:0]} | 5'd1;
            issue(r_type(7'h01, {1'b0, r[7:4]}, {1'b0, r[11:8]}, F3_ADD_SUB, rd),
                  "illegal_op");
            issue(i_type(r[31:20], 5'd1, 3'b010, rd, 7'b0000011), "illegal_load");
            issue(r_type(7'h00, 5'd0, rd, F3_OR, 5'd7), "illegal_readback");
        end
        // x0 write dropped and never forwarded
        issue(i_type(12'h05a, 5'd1, F3_ADD_SUB, 5'd0, OPC_OP_IMM), "x0_write");
        issue(r_type(7'h00, 5'd0, 5'd0, F3_ADD_SUB, 5'd8), "x0_read");
        idle(1);
        drain();
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
